/* design/cpu_pkg.sv */
// Shared widths, opcodes, operation codes and instruction formats for the decode stage.
`default_nettype none

package cpu_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_num    = 1 << reg_addr_w;
    localparam int opcode_w   = 6;
    localparam int imm_w      = 16;
    localparam int alu_op_w   = 3;
    localparam int cmp_op_w   = 2;
    localparam int mem_op_w   = 2;
    localparam int ex_sel_w   = 2;

    // ------------------------------------------------------------------------
    // opcodes, all other values are undefined
    // ------------------------------------------------------------------------
    localparam logic [opcode_w-1:0] op_add  = 6'h01;    // rc = ra + rb
    localparam logic [opcode_w-1:0] op_sub  = 6'h02;
    localparam logic [opcode_w-1:0] op_and  = 6'h03;
    localparam logic [opcode_w-1:0] op_or   = 6'h04;
    localparam logic [opcode_w-1:0] op_xor  = 6'h05;
    localparam logic [opcode_w-1:0] op_addi = 6'h08;    // signed immediate
    localparam logic [opcode_w-1:0] op_ori  = 6'h09;    // unsigned immediate
    localparam logic [opcode_w-1:0] op_ldw  = 6'h10;
    localparam logic [opcode_w-1:0] op_stw  = 6'h11;
    localparam logic [opcode_w-1:0] op_beq  = 6'h18;
    localparam logic [opcode_w-1:0] op_bne  = 6'h19;
    localparam logic [opcode_w-1:0] op_jr   = 6'h20;
    localparam logic [opcode_w-1:0] op_call = 6'h21;    // jr plus link to r31

    // ------------------------------------------------------------------------
    // operation codes handed to execute and memory
    // ------------------------------------------------------------------------
    localparam logic [alu_op_w-1:0] alu_nop = 3'd0;
    localparam logic [alu_op_w-1:0] alu_add = 3'd1;
    localparam logic [alu_op_w-1:0] alu_sub = 3'd2;
    localparam logic [alu_op_w-1:0] alu_and = 3'd3;
    localparam logic [alu_op_w-1:0] alu_or  = 3'd4;
    localparam logic [alu_op_w-1:0] alu_xor = 3'd5;

    localparam logic [cmp_op_w-1:0] cmp_nop = 2'd0;
    localparam logic [cmp_op_w-1:0] cmp_eq  = 2'd1;
    localparam logic [cmp_op_w-1:0] cmp_ne  = 2'd2;

    localparam logic [mem_op_w-1:0] mem_nop = 2'd0;
    localparam logic [mem_op_w-1:0] mem_ldw = 2'd1;    // also selects memory for writeback
    localparam logic [mem_op_w-1:0] mem_stw = 2'd2;

    localparam logic [ex_sel_w-1:0] ex_sel_alu  = 2'd0;
    localparam logic [ex_sel_w-1:0] ex_sel_link = 2'd1;

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // ------------------------------------------------------------------------
    // instruction word, register and immediate views
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
        logic [reg_addr_w-1:0] rc;
        logic [10:0]           unused;
    } insn_r_t;

    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] ra;
        logic [reg_addr_w-1:0] rb;
        logic [imm_w-1:0]      imm;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

endpackage

`default_nettype wire

/* design/decoder.sv */
// Combinational decode of one fetched word into operations, operands and writeback controls.
`default_nettype none

module decoder import cpu_pkg::*; (
    input  wire insn_u                 insn,
    input  wire logic [word_w-1:0]     pc,
    input  wire logic                  if_en,       // fetch slot valid
    input  wire logic [word_w-1:0]     ra_data,
    input  wire logic [word_w-1:0]     rb_data,
    output logic [reg_addr_w-1:0]      ra_addr,
    output logic [reg_addr_w-1:0]      rb_addr,
    output logic [alu_op_w-1:0]        alu_op,
    output logic [word_w-1:0]          alu_in_0,
    output logic [word_w-1:0]          alu_in_1,
    output logic [cmp_op_w-1:0]        cmp_op,
    output logic [word_w-1:0]          cmp_in_0,
    output logic [word_w-1:0]          cmp_in_1,
    output logic                       jump_taken,
    output logic [mem_op_w-1:0]        mem_op,
    output logic [word_w-1:0]          mem_wr_data,
    output logic [reg_addr_w-1:0]      dst_addr,
    output logic                       gpr_we,
    output logic [ex_sel_w-1:0]        ex_sel,
    output logic [word_w-1:0]          gpr_wr_data  // link value for call
);

    logic              insn_ok;                     // valid slot, defined opcode
    logic [word_w-1:0] imm_sext;
    logic [word_w-1:0] imm_zext;

    assign imm_sext = {{(word_w-imm_w){insn.i.imm[imm_w-1]}}, insn.i.imm};
    assign imm_zext = {{(word_w-imm_w){1'b0}}, insn.i.imm};

    always_comb begin
        case (insn.r.opcode)
            op_add, op_sub, op_and, op_or, op_xor,
            op_addi, op_ori, op_ldw, op_stw,
            op_beq, op_bne, op_jr, op_call: insn_ok = if_en;
            default:                        insn_ok = 1'b0;
        endcase
    end

    // read ports park on r0 for a bubble
    assign ra_addr = insn_ok ? insn.r.ra : '0;
    assign rb_addr = insn_ok ? insn.r.rb : '0;

    // ------------------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------------------
    always_comb begin
        alu_op      = alu_nop;
        alu_in_0    = '0;
        alu_in_1    = '0;
        cmp_op      = cmp_nop;
        cmp_in_0    = '0;
        cmp_in_1    = '0;
        jump_taken  = 1'b0;
        mem_op      = mem_nop;
        mem_wr_data = '0;
        dst_addr    = '0;
        gpr_we      = 1'b0;
        ex_sel      = ex_sel_alu;
        gpr_wr_data = '0;

        if (insn_ok) begin
            case (insn.r.opcode)
                op_add, op_sub, op_and, op_or, op_xor: begin
                    case (insn.r.opcode)
                        op_add:  alu_op = alu_add;
                        op_sub:  alu_op = alu_sub;
                        op_and:  alu_op = alu_and;
                        op_or:   alu_op = alu_or;
                        default: alu_op = alu_xor;
                    endcase
                    alu_in_0 = ra_data;
                    alu_in_1 = rb_data;
                    dst_addr = insn.r.rc;
                    gpr_we   = 1'b1;
                end
                op_addi, op_ori: begin
                    alu_op   = (insn.i.opcode == op_addi) ? alu_add : alu_or;
                    alu_in_0 = ra_data;
                    alu_in_1 = (insn.i.opcode == op_addi) ? imm_sext : imm_zext;
                    dst_addr = insn.i.rb;
                    gpr_we   = 1'b1;
                end
                op_ldw: begin
                    alu_op   = alu_add;             // effective address
                    alu_in_0 = ra_data;
                    alu_in_1 = imm_sext;
                    mem_op   = mem_ldw;
                    dst_addr = insn.i.rb;
                    gpr_we   = 1'b1;
                end
                op_stw: begin
                    alu_op      = alu_add;
                    alu_in_0    = ra_data;
                    alu_in_1    = imm_sext;
                    mem_op      = mem_stw;
                    mem_wr_data = rb_data;
                end
                op_beq, op_bne: begin
                    cmp_op   = (insn.r.opcode == op_beq) ? cmp_eq : cmp_ne;
                    cmp_in_0 = ra_data;
                    cmp_in_1 = rb_data;
                end
                op_jr, op_call: begin
                    jump_taken = 1'b1;
                    alu_op     = alu_add;           // target passes through ALU
                    alu_in_0   = ra_data;
                    if (insn.r.opcode == op_call) begin
                        dst_addr    = link_reg;
                        gpr_we      = 1'b1;
                        ex_sel      = ex_sel_link;
                        gpr_wr_data = pc + word_w'(4);
                    end
                end
                default: ;                          // filtered by insn_ok
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/gpr_file.sv */
// Register file of the decode stage with two async read ports and a bypassed sync write port.
`default_nettype none

module gpr_file import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [reg_addr_w-1:0] ra_addr,
    input  wire logic [reg_addr_w-1:0] rb_addr,
    input  wire logic                  wb_we,
    input  wire logic [reg_addr_w-1:0] wb_addr,
    input  wire logic [word_w-1:0]     wb_data,
    output logic [word_w-1:0]          ra_data,
    output logic [word_w-1:0]          rb_data
);

    logic [word_w-1:0] regs [reg_num];

    // ------------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_addr != '0) begin     // r0 stays zero
            regs[wb_addr] <= wb_data;
        end
    end

    // ------------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------------
    function automatic logic [word_w-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [word_w-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_we && wb_addr == addr) begin
            data = wb_data;                             // same-cycle bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    // reevaluated on writeback and array changes too
    always_comb begin
        ra_data = read_port(ra_addr);
        rb_data = read_port(rb_addr);
    end

    // an unknown write address would corrupt an arbitrary register
    a_wb_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        wb_we |-> !$isunknown(wb_addr)
    ) else $error("gpr_file: wb_addr unknown during write");

endmodule

`default_nettype wire

/* design/id_reg.sv */
// ID/EX pipeline register, holds on stall, clears to a bubble on flush, loads otherwise.
`default_nettype none

module id_reg import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  stall,       // wins over flush
    input  wire logic                  flush,
    input  wire logic                  if_en,
    input  wire logic [alu_op_w-1:0]   alu_op,
    input  wire logic [word_w-1:0]     alu_in_0,
    input  wire logic [word_w-1:0]     alu_in_1,
    input  wire logic [cmp_op_w-1:0]   cmp_op,
    input  wire logic [word_w-1:0]     cmp_in_0,
    input  wire logic [word_w-1:0]     cmp_in_1,
    input  wire logic [reg_addr_w-1:0] ra_addr,
    input  wire logic [reg_addr_w-1:0] rb_addr,
    input  wire logic                  jump_taken,
    input  wire logic [mem_op_w-1:0]   mem_op,
    input  wire logic [word_w-1:0]     mem_wr_data,
    input  wire logic [reg_addr_w-1:0] dst_addr,
    input  wire logic                  gpr_we,
    input  wire logic [ex_sel_w-1:0]   ex_sel,
    input  wire logic [word_w-1:0]     gpr_wr_data,
    output logic                       id_en,
    output logic [alu_op_w-1:0]        id_alu_op,
    output logic [word_w-1:0]          id_alu_in_0,
    output logic [word_w-1:0]          id_alu_in_1,
    output logic [cmp_op_w-1:0]        id_cmp_op,
    output logic [word_w-1:0]          id_cmp_in_0,
    output logic [word_w-1:0]          id_cmp_in_1,
    output logic [reg_addr_w-1:0]      id_ra_addr,
    output logic [reg_addr_w-1:0]      id_rb_addr,
    output logic                       id_jump_taken,
    output logic [mem_op_w-1:0]        id_mem_op,
    output logic [word_w-1:0]          id_mem_wr_data,
    output logic [reg_addr_w-1:0]      id_dst_addr,
    output logic                       id_gpr_we,
    output logic [ex_sel_w-1:0]        id_ex_sel,
    output logic [word_w-1:0]          id_gpr_wr_data
);

    // ------------------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || (flush && !stall)) begin           // bubble
            id_en          <= 1'b0;
            id_alu_op      <= alu_nop;
            id_alu_in_0    <= '0;
            id_alu_in_1    <= '0;
            id_cmp_op      <= cmp_nop;
            id_cmp_in_0    <= '0;
            id_cmp_in_1    <= '0;
            id_ra_addr     <= '0;
            id_rb_addr     <= '0;
            id_jump_taken  <= 1'b0;
            id_mem_op      <= mem_nop;
            id_mem_wr_data <= '0;
            id_dst_addr    <= '0;
            id_gpr_we      <= 1'b0;
            id_ex_sel      <= ex_sel_alu;
            id_gpr_wr_data <= '0;
        end else if (!stall) begin
            id_en          <= if_en;
            id_alu_op      <= alu_op;
            id_alu_in_0    <= alu_in_0;
            id_alu_in_1    <= alu_in_1;
            id_cmp_op      <= cmp_op;
            id_cmp_in_0    <= cmp_in_0;
            id_cmp_in_1    <= cmp_in_1;
            id_ra_addr     <= ra_addr;
            id_rb_addr     <= rb_addr;
            id_jump_taken  <= jump_taken;
            id_mem_op      <= mem_op;
            id_mem_wr_data <= mem_wr_data;
            id_dst_addr    <= dst_addr;
            id_gpr_we      <= gpr_we;
            id_ex_sel      <= ex_sel;
            id_gpr_wr_data <= gpr_wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        ($past(stall) && !$past(reset)) |->
            $stable({id_en, id_alu_op, id_alu_in_0, id_alu_in_1, id_cmp_op,
                     id_cmp_in_0, id_cmp_in_1, id_ra_addr, id_rb_addr,
                     id_jump_taken, id_mem_op, id_mem_wr_data, id_dst_addr,
                     id_gpr_we, id_ex_sel, id_gpr_wr_data})
    ) else $error("id_reg: outputs moved while stalled");

    // a bubble must never write a register or redirect fetch
    a_bubble_quiet: assert property (
        @(posedge clk) disable iff (reset)
        !id_en |-> (!id_gpr_we && !id_jump_taken)
    ) else $error("id_reg: write or jump in an invalid slot");

endmodule

`default_nettype wire

/* design/id_stage.sv */
// Decode stage top, wires decoder and register file into the ID/EX register.
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire insn_u                 insn,
    input  wire logic [word_w-1:0]     pc,
    input  wire logic                  if_en,
    input  wire logic                  stall,
    input  wire logic                  flush,
    input  wire logic                  wb_we,
    input  wire logic [reg_addr_w-1:0] wb_addr,
    input  wire logic [word_w-1:0]     wb_data,
    output logic                       id_en,
    output logic [alu_op_w-1:0]        id_alu_op,
    output logic [word_w-1:0]          id_alu_in_0,
    output logic [word_w-1:0]          id_alu_in_1,
    output logic [cmp_op_w-1:0]        id_cmp_op,
    output logic [word_w-1:0]          id_cmp_in_0,
    output logic [word_w-1:0]          id_cmp_in_1,
    output logic [reg_addr_w-1:0]      id_ra_addr,
    output logic [reg_addr_w-1:0]      id_rb_addr,
    output logic                       id_jump_taken,
    output logic [mem_op_w-1:0]        id_mem_op,
    output logic [word_w-1:0]          id_mem_wr_data,
    output logic [reg_addr_w-1:0]      id_dst_addr,
    output logic                       id_gpr_we,
    output logic [ex_sel_w-1:0]        id_ex_sel,
    output logic [word_w-1:0]          id_gpr_wr_data
);

    logic [reg_addr_w-1:0] ra_addr, rb_addr;        // also forwarded to execute
    logic [word_w-1:0]     ra_data, rb_data;
    logic [alu_op_w-1:0]   alu_op;
    logic [word_w-1:0]     alu_in_0, alu_in_1;
    logic [cmp_op_w-1:0]   cmp_op;
    logic [word_w-1:0]     cmp_in_0, cmp_in_1;
    logic                  jump_taken;
    logic [mem_op_w-1:0]   mem_op;
    logic [word_w-1:0]     mem_wr_data;
    logic [reg_addr_w-1:0] dst_addr;
    logic                  gpr_we;
    logic [ex_sel_w-1:0]   ex_sel;
    logic [word_w-1:0]     gpr_wr_data;

    decoder i_decoder (
        .insn, .pc, .if_en, .ra_data, .rb_data,
        .ra_addr, .rb_addr,
        .alu_op, .alu_in_0, .alu_in_1,
        .cmp_op, .cmp_in_0, .cmp_in_1,
        .jump_taken, .mem_op, .mem_wr_data,
        .dst_addr, .gpr_we, .ex_sel, .gpr_wr_data
    );

    gpr_file i_gpr_file (
        .clk, .reset, .ra_addr, .rb_addr,
        .wb_we, .wb_addr, .wb_data,
        .ra_data, .rb_data
    );

    id_reg i_id_reg (
        .clk, .reset, .stall, .flush, .if_en,
        .alu_op, .alu_in_0, .alu_in_1,
        .cmp_op, .cmp_in_0, .cmp_in_1,
        .ra_addr, .rb_addr,
        .jump_taken, .mem_op, .mem_wr_data,
        .dst_addr, .gpr_we, .ex_sel, .gpr_wr_data,
        .id_en, .id_alu_op, .id_alu_in_0, .id_alu_in_1,
        .id_cmp_op, .id_cmp_in_0, .id_cmp_in_1,
        .id_ra_addr, .id_rb_addr,
        .id_jump_taken, .id_mem_op, .id_mem_wr_data,
        .id_dst_addr, .id_gpr_we, .id_ex_sel, .id_gpr_wr_data
    );

endmodule

`default_nettype wire

/* tb/id_checker.sv */
// Reference model of the decode stage, predicts the ID/EX outputs and compares them once per cycle.
`default_nettype none

module id_checker import cpu_pkg::*; (
    input  wire logic                  clk, reset, if_en, stall, flush, wb_we,
    input  wire logic [word_w-1:0]     insn, pc, wb_data,
    input  wire logic [reg_addr_w-1:0] wb_addr,
    input  wire logic                  id_en, id_jump_taken, id_gpr_we,
    input  wire logic [alu_op_w-1:0]   id_alu_op,
    input  wire logic [cmp_op_w-1:0]   id_cmp_op,
    input  wire logic [mem_op_w-1:0]   id_mem_op,
    input  wire logic [ex_sel_w-1:0]   id_ex_sel,
    input  wire logic [word_w-1:0]     id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1,
    input  wire logic [word_w-1:0]     id_mem_wr_data, id_gpr_wr_data,
    input  wire logic [reg_addr_w-1:0] id_ra_addr, id_rb_addr, id_dst_addr,
    output int                         errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [word_w-1:0]     regs [reg_num];          // model register file
    bit                    armed;                   // set by the first reset edge
    logic                  e_en, e_jump, e_we;      // expected ID/EX contents
    logic [alu_op_w-1:0]   e_alu_op;
    logic [cmp_op_w-1:0]   e_cmp_op;
    logic [mem_op_w-1:0]   e_mem_op;
    logic [ex_sel_w-1:0]   e_ex_sel;
    logic [word_w-1:0]     e_alu_in_0, e_alu_in_1, e_cmp_in_0, e_cmp_in_1;
    logic [word_w-1:0]     e_mem_wr_data, e_wr_data;
    logic [reg_addr_w-1:0] e_ra, e_rb, e_dst;

    // r0 reads zero, a same-cycle writeback is seen at once
    function automatic logic [word_w-1:0] read_reg(input logic [reg_addr_w-1:0] addr);
        return (addr == '0) ? '0 : (wb_we && wb_addr == addr) ? wb_data : regs[addr];
    endfunction

    // ------------------------------------------------------------------------
    // expected slot, a bubble unless the slot is valid and the opcode defined
    // ------------------------------------------------------------------------
    task automatic expect_slot(input logic slot_en);
        logic [opcode_w-1:0] opc;
        logic [word_w-1:0]   va, vb, sext;
        opc  = insn[31:26];
        va   = read_reg(insn[25:21]);
        vb   = read_reg(insn[20:16]);
        sext = {{16{insn[15]}}, insn[15:0]};
        {e_alu_op, e_cmp_op, e_mem_op, e_ex_sel} = {alu_nop, cmp_nop, mem_nop, ex_sel_alu};
        {e_alu_in_0, e_alu_in_1, e_cmp_in_0, e_cmp_in_1, e_mem_wr_data, e_wr_data} = '0;
        {e_ra, e_rb, e_dst, e_jump, e_we} = '0;
        e_en = slot_en;
        if (slot_en && opc inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_ori,
                                   op_ldw, op_stw, op_beq, op_bne, op_jr, op_call}) begin
            e_ra       = insn[25:21];
            e_rb       = insn[20:16];
            e_alu_in_0 = va;                        // ra feeds the ALU except for compares
            case (opc)
                op_add, op_sub, op_and, op_or, op_xor: begin
                    e_alu_op   = (opc == op_add) ? alu_add : (opc == op_sub) ? alu_sub :
                                 (opc == op_and) ? alu_and : (opc == op_or) ? alu_or : alu_xor;
                    e_alu_in_1 = vb;
                    e_dst      = insn[15:11];
                    e_we       = 1'b1;
                end
                op_addi, op_ori, op_ldw, op_stw: begin
                    e_alu_op      = (opc == op_ori) ? alu_or : alu_add;
                    e_alu_in_1    = (opc == op_ori) ? {16'h0, insn[15:0]} : sext;
                    e_mem_op      = (opc == op_ldw) ? mem_ldw : (opc == op_stw) ? mem_stw : mem_nop;
                    e_mem_wr_data = (opc == op_stw) ? vb : '0;
                    e_dst         = (opc == op_stw) ? '0 : insn[20:16];
                    e_we          = (opc != op_stw);
                end
                op_beq, op_bne: begin
                    e_alu_in_0 = '0;
                    e_cmp_op   = (opc == op_beq) ? cmp_eq : cmp_ne;
                    e_cmp_in_0 = va;
                    e_cmp_in_1 = vb;
                end
                default: begin                      // jr and call, target is ra
                    e_alu_op = alu_add;
                    e_jump   = 1'b1;
                    if (opc == op_call) begin
                        e_dst     = 5'd31;          // link register
                        e_we      = 1'b1;
                        e_ex_sel  = ex_sel_link;
                        e_wr_data = pc + 32'd4;
                    end
                end
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            armed = 1'b1;
            expect_slot(1'b0);
            foreach (regs[i]) regs[i] = '0;
        end else begin
            if (!stall) begin                       // a stall holds, even over flush
                expect_slot(flush ? 1'b0 : if_en);
            end
            if (wb_we && wb_addr != '0) begin
                regs[wb_addr] = wb_data;
            end
        end
    end

    task automatic compare(input string name, input logic [word_w-1:0] exp_val,
                           input logic [word_w-1:0] act_val);
        if (act_val !== exp_val) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %0h, got %0h", $time, name, exp_val, act_val);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (armed) begin
            compare("id_en", e_en, id_en);
            compare("id_alu_op", e_alu_op, id_alu_op);
            compare("id_alu_in_0", e_alu_in_0, id_alu_in_0);
            compare("id_alu_in_1", e_alu_in_1, id_alu_in_1);
            compare("id_cmp_op", e_cmp_op, id_cmp_op);
            compare("id_cmp_in_0", e_cmp_in_0, id_cmp_in_0);
            compare("id_cmp_in_1", e_cmp_in_1, id_cmp_in_1);
            compare("id_ra_addr", e_ra, id_ra_addr);
            compare("id_rb_addr", e_rb, id_rb_addr);
            compare("id_jump_taken", e_jump, id_jump_taken);
            compare("id_mem_op", e_mem_op, id_mem_op);
            compare("id_mem_wr_data", e_mem_wr_data, id_mem_wr_data);
            compare("id_dst_addr", e_dst, id_dst_addr);
            compare("id_gpr_we", e_we, id_gpr_we);
            compare("id_ex_sel", e_ex_sel, id_ex_sel);
            compare("id_gpr_wr_data", e_wr_data, id_gpr_wr_data);
        end
    end

endmodule

`default_nettype wire

/* tb/tb_id_stage.sv */
// Testbench top for the decode stage, runs seeded random phases and prints the closing report.
`default_nettype none

module tb_id_stage import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 20;
    localparam int n_decode   = 300;
    localparam int n_regs     = 300;
    localparam int n_stall    = 300;
    localparam int n_flush    = 200;
    localparam int n_total    = 2 + n_decode + n_regs + n_stall + n_flush + 4;
    localparam int n_margin   = 100;
    localparam logic [opcode_w-1:0] legal_ops [13] = '{op_add, op_sub, op_and, op_or, op_xor,
        op_addi, op_ori, op_ldw, op_stw, op_beq, op_bne, op_jr, op_call};

    logic                  clk, reset, if_en, stall, flush, wb_we;
    logic [word_w-1:0]     insn, pc, wb_data;
    logic [reg_addr_w-1:0] wb_addr;
    logic                  id_en, id_jump_taken, id_gpr_we;
    logic [alu_op_w-1:0]   id_alu_op;
    logic [cmp_op_w-1:0]   id_cmp_op;
    logic [mem_op_w-1:0]   id_mem_op;
    logic [ex_sel_w-1:0]   id_ex_sel;
    logic [word_w-1:0]     id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1;
    logic [word_w-1:0]     id_mem_wr_data, id_gpr_wr_data;
    logic [reg_addr_w-1:0] id_ra_addr, id_rb_addr, id_dst_addr;
    int                    errors;

    id_stage i_dut (.*);
    id_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_total + n_margin) * clk_period);
        $display("watchdog: simulation timed out after %0d cycles", n_total + n_margin);
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // one random phase, chances given in percent
    // ------------------------------------------------------------------------
    task automatic run_phase(input int cycles, input int p_wb, input int p_stall,
                             input int p_flush, input int p_idle);
        repeat (cycles) begin
            @(posedge clk);
            #2;                                     // drive clear of the edge
            stall = ($urandom_range(99) < p_stall);
            flush = ($urandom_range(99) < p_flush);
            if (!stall) begin                       // fetch holds its slot while stalled
                insn        = $urandom;
                insn[31:26] = ($urandom_range(9) < 8) ? legal_ops[$urandom_range(12)]
                                                      : insn[31:26];
                pc          = $urandom & 32'hffff_fffc;
                if_en       = ($urandom_range(99) >= p_idle);
            end
            wb_we   = ($urandom_range(99) < p_wb);
            wb_data = $urandom;
            case ($urandom_range(3))
                0:       wb_addr = insn[25:21];     // same-cycle read of ra
                1:       wb_addr = insn[20:16];
                2:       wb_addr = '0;
                default: wb_addr = 5'($urandom);
            endcase
        end
    endtask

    initial begin
        void'($urandom(24948));
        reset = 1'b1;
        {if_en, stall, flush, wb_we} = '0;
        {insn, pc, wb_data, wb_addr} = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        run_phase(n_decode, 0, 0, 0, 10);           // decode against empty registers
        run_phase(n_regs, 70, 0, 0, 5);             // writebacks and bypass
        run_phase(n_stall, 40, 30, 20, 10);         // stall, often with flush
        run_phase(n_flush, 30, 0, 25, 25);          // flush and idle slots
        @(posedge clk);
        #2;
        {if_en, stall, flush, wb_we} = '0;
        repeat (3) @(posedge clk);
        $display("closing report: %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
design/cpu_pkg.sv
design/decoder.sv
design/gpr_file.sv
design/id_reg.sv
design/id_stage.sv
tb/id_checker.sv
tb/tb_id_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_id_stage -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_id_stage)"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
